// File: common/reset_timing_pkg.sv
package reset_timing_pkg;

    // ----------------------------------------------------------------------
    // Reset sequence timing
    // ----------------------------------------------------------------------

    // Cycles of axil_aclk spent in the wait state
    // Sets the minimum AXI-Lite reset assertion after release
    localparam int RESET_DURATION = 100;

    // Timer wide enough to hold RESET_DURATION
    localparam int TIMER_WID = $clog2(RESET_DURATION + 1);

    // ----------------------------------------------------------------------
    // Synchronizer depth
    // ----------------------------------------------------------------------

    // Flops per reset synchronizer
    // Applies to both the input and the core-domain stage
    localparam int SYNC_STAGES = 3;

    // ----------------------------------------------------------------------
    // Derived latency
    // ----------------------------------------------------------------------

    // Input sync, wait state, then entry edge and output register
    // Edges from mod_rstn release to axil_aresetn high
    localparam int RELEASE_EDGES = SYNC_STAGES + RESET_DURATION + 2;

endpackage : reset_timing_pkg

// File: common/reset_types_pkg.sv
package reset_types_pkg;

    // ----------------------------------------------------------------------
    // Sequencer state encoding
    // ----------------------------------------------------------------------

    // Bits in the state register
    localparam int SEQ_STATE_WID = 2;

    // SEQ_RESET holds the timer cleared while reset is active
    // SEQ_WAIT counts out the minimum duration
    // SEQ_DONE lets the AXI-Lite reset go
    typedef enum logic [SEQ_STATE_WID-1:0] {
        // Held here while __reset is high
        SEQ_RESET = 2'd0,
        // Timer running
        SEQ_WAIT  = 2'd1,
        // Sequence complete
        SEQ_DONE  = 2'd2
    } seq_state_t;

    // Encoding 2'd3 is unused
    // The FSM falls back to SEQ_RESET from it

endpackage : reset_types_pkg

// File: design/sync_reset.sv
`timescale 1ns/1ps

module sync_reset #(
    // 0 gives an active-high output, 1 an active-low one
    parameter bit OUTPUT_ACTIVE_LOW = 1'b0
) (
    // Asynchronous reset, active low
    input  logic rst_in,
    // Destination clock
    input  logic clk_out,
    // Synchronized reset in the chosen polarity
    output logic srst_out
);

    // ----------------------------------------------------------------------
    // Release shift register
    // ----------------------------------------------------------------------

    // Each bit set means "released" up to that stage
    logic [reset_timing_pkg::SYNC_STAGES-1:0] sync_q;

    // Last stage, high once the release has crossed over
    logic released;

    // Assert at once on rst_in low
    // Release walks through the chain one clk_out edge per stage
    always_ff @(posedge clk_out or negedge rst_in) begin
        if (!rst_in) begin
            sync_q <= '0;
        end else begin
            // Shift a one in from the bottom
            sync_q <= {sync_q[reset_timing_pkg::SYNC_STAGES-2:0], 1'b1};
        end
    end

    // Output of the final flop
    assign released = sync_q[reset_timing_pkg::SYNC_STAGES-1];

    // ----------------------------------------------------------------------
    // Output polarity
    // ----------------------------------------------------------------------

    // Active low: high once released
    // Active high: low once released
    always_comb begin
        if (OUTPUT_ACTIVE_LOW) begin
            srst_out = released;
        end else begin
            srst_out = ~released;
        end
    end

    // Assertion path stays async through the flop clear
    // Release is always clean in the clk_out domain

endmodule : sync_reset

// File: design/reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer (
    // AXI-Lite clock
    input  logic axil_aclk,
    // Synchronized reset, active high
    input  logic __reset,
    // Stretched AXI-Lite reset, active low, registered
    output logic axil_aresetn
);

    // ----------------------------------------------------------------------
    // Signals
    // ----------------------------------------------------------------------

    // Current and next FSM state
    reset_types_pkg::seq_state_t state;
    reset_types_pkg::seq_state_t nxt_state;

    // Wait-state timer
    logic [reset_timing_pkg::TIMER_WID-1:0] timer;
    // Timer controls from the FSM
    logic timer_clr;
    logic timer_inc;
    // Last count of the wait phase
    logic timer_expired;

    // Sequence finished, registered onto axil_aresetn
    logic reset_done;

    // ----------------------------------------------------------------------
    // State register
    // ----------------------------------------------------------------------

    // Any reassertion restarts from SEQ_RESET
    always_ff @(posedge axil_aclk) begin
        if (__reset) begin
            state <= reset_types_pkg::SEQ_RESET;
        end else begin
            state <= nxt_state;
        end
    end

    // Timer reaches RESET_DURATION-1 on the last wait cycle
    assign timer_expired =
        (timer == reset_timing_pkg::TIMER_WID'(reset_timing_pkg::RESET_DURATION - 1));

    // ----------------------------------------------------------------------
    // Next-state logic
    // ----------------------------------------------------------------------

    always_comb begin
        // Defaults
        nxt_state  = state;
        timer_clr  = 1'b0;
        timer_inc  = 1'b0;
        reset_done = 1'b0;
        case (state)
            reset_types_pkg::SEQ_RESET: begin
                // Leave on the first edge with __reset low
                timer_clr = 1'b1;
                nxt_state = reset_types_pkg::SEQ_WAIT;
            end
            reset_types_pkg::SEQ_WAIT: begin
                timer_inc = 1'b1;
                if (timer_expired) begin
                    nxt_state = reset_types_pkg::SEQ_DONE;
                end
            end
            reset_types_pkg::SEQ_DONE: begin
                // Stay until __reset comes back
                reset_done = 1'b1;
            end
            default: begin
                // Unused encoding
                nxt_state = reset_types_pkg::SEQ_RESET;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // Timer
    // ----------------------------------------------------------------------

    // Cleared in SEQ_RESET, counts only in SEQ_WAIT
    always_ff @(posedge axil_aclk) begin
        if (__reset || timer_clr) begin
            timer <= '0;
        end else if (timer_inc) begin
            timer <= timer + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Output register
    // ----------------------------------------------------------------------

    // Drops on the first edge that sees __reset high
    // Rises one edge after SEQ_DONE is entered
    always_ff @(posedge axil_aclk) begin
        if (__reset) begin
            axil_aresetn <= 1'b0;
        end else begin
            axil_aresetn <= reset_done;
        end
    end

endmodule : reset_sequencer

// File: design/nic_reset_ctrl.sv
`timescale 1ns/1ps

module nic_reset_ctrl (
    // Module reset from the shell, async, active low
    input  logic mod_rstn,
    // AXI-Lite clock
    input  logic axil_aclk,
    // AXIS clock, also the core clock
    input  logic axis_aclk,
    // Sequence complete
    output logic mod_rst_done,
    // AXI-Lite reset, active low
    output logic axil_aresetn,
    // Core-domain reset, active low
    output logic core_rstn,
    // Core clock
    output logic core_clk
);

    // ----------------------------------------------------------------------
    // Signals
    // ----------------------------------------------------------------------

    // Synchronized module reset, active high, axil_aclk domain
    logic __reset;

    // ----------------------------------------------------------------------
    // Clocks
    // ----------------------------------------------------------------------

    // Core runs on the AXIS clock
    assign core_clk = axis_aclk;

    // ----------------------------------------------------------------------
    // Reset pipeline
    // ----------------------------------------------------------------------

    // Stage 1
    // Bring mod_rstn into axil_aclk, active-high output
    sync_reset #(
        .OUTPUT_ACTIVE_LOW (1'b0)
    ) u_sync_in (
        .rst_in   (mod_rstn),
        .clk_out  (axil_aclk),
        .srst_out (__reset)
    );

    // Stage 2
    // Hold AXI-Lite reset for the minimum duration
    reset_sequencer u_seq (
        .axil_aclk    (axil_aclk),
        .__reset      (__reset),
        .axil_aresetn (axil_aresetn)
    );

    // Stage 3
    // Re-sync into the core domain, active-low output
    // Assertion follows axil_aresetn without waiting for a clock
    sync_reset #(
        .OUTPUT_ACTIVE_LOW (1'b1)
    ) u_sync_core (
        .rst_in   (axil_aresetn),
        .clk_out  (core_clk),
        .srst_out (core_rstn)
    );

    // ----------------------------------------------------------------------
    // Status
    // ----------------------------------------------------------------------

    // Done tracks the AXI-Lite reset release
    assign mod_rst_done = axil_aresetn;

endmodule : nic_reset_ctrl

// File: dv/tb_nic_reset_ctrl.sv
`timescale 1ns/1ps

module tb_nic_reset_ctrl;

    // ----------------------------------------------------------------------
    // DUT signals
    // ----------------------------------------------------------------------

    logic mod_rstn;
    logic axil_aclk;
    logic axis_aclk;
    logic mod_rst_done;
    logic axil_aresetn;
    logic core_rstn;
    logic core_clk;

    // Stimulus seed
    int seed;
    // Edges since the last mod_rstn release
    // Held at -1 while mod_rstn is low
    int since_release;
    // Edges seen with mod_rstn low
    int low_edges;
    // axis_aclk rising edges since axil_aresetn went high
    int core_edges;
    // Stimulus scratch
    int gap;
    // Expected levels
    logic exp_aresetn;
    logic exp_core;

    // 100 ns AXI-Lite clock and 40 ns AXIS clock
    always #50 axil_aclk = ~axil_aclk;
    always #20 axis_aclk = ~axis_aclk;

    nic_reset_ctrl dut0 (
        .mod_rstn     (mod_rstn),
        .axil_aclk    (axil_aclk),
        .axis_aclk    (axis_aclk),
        .mod_rst_done (mod_rst_done),
        .axil_aresetn (axil_aresetn),
        .core_rstn    (core_rstn),
        .core_clk     (core_clk)
    );

    // ----------------------------------------------------------------------
    // Reference model and helpers
    // ----------------------------------------------------------------------

    // Input sync depth, wait phase, entry edge into SEQ_WAIT, output register
    function automatic int expected_release_edges();
        return reset_timing_pkg::SYNC_STAGES + reset_timing_pkg::RESET_DURATION + 2;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] r;
        r = $random(seed);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        reset_types_pkg::seq_state_t st;
        st = dut0.u_seq.state;
        $display("MISMATCH %s expected 0x%0h actual 0x%0h (edge %0d, state %s)",
                 sig, exp, act, since_release, st.name());
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // Hold low for the given number of axil_aclk cycles and release
    task automatic pulse_reset(input int cycles);
        @(posedge axil_aclk);
        mod_rstn <= 1'b0;
        repeat (cycles) @(posedge axil_aclk);
        mod_rstn <= 1'b1;
    endtask

    task automatic wait_axil_release();
        int cnt;
        cnt = 0;
        do begin
            @(negedge axil_aclk);
            cnt++;
            if (cnt > expected_release_edges() + 4)
                report_timeout("axil_aresetn to rise after mod_rstn release");
        end while (axil_aresetn !== 1'b1);
    endtask

    task automatic wait_core_release();
        int cnt;
        cnt = 0;
        do begin
            @(negedge axis_aclk);
            cnt++;
            if (cnt > reset_timing_pkg::SYNC_STAGES + 2)
                report_timeout("core_rstn to follow axil_aresetn");
        end while (core_rstn !== 1'b1);
    endtask

    // ----------------------------------------------------------------------
    // AXI-Lite domain comparison
    // ----------------------------------------------------------------------

    // Outputs checked mid-cycle on the falling edge
    always @(negedge axil_aclk) begin
        if (mod_rstn === 1'b0) begin
            low_edges = low_edges + 1;
            since_release = -1;
        end else begin
            low_edges = 0;
            since_release = since_release + 1;
        end
        if (since_release >= 0) begin
            exp_aresetn = (since_release >= expected_release_edges());
            assert (axil_aresetn === exp_aresetn) else
                report_mismatch("axil_aresetn", exp_aresetn, axil_aresetn);
            // Done flag follows the same release edge
            assert (mod_rst_done === exp_aresetn) else
                report_mismatch("mod_rst_done", exp_aresetn, mod_rst_done);
            if (since_release == expected_release_edges()) begin
                // FSM sits in SEQ_DONE once the output is up
                assert (dut0.u_seq.state === reset_types_pkg::SEQ_DONE) else
                    report_mismatch("u_seq.state", reset_types_pkg::SEQ_DONE,
                                    dut0.u_seq.state);
            end
        end else if (low_edges >= 2) begin
            // Everything in reset one edge after mod_rstn falls
            assert (axil_aresetn === 1'b0) else
                report_mismatch("axil_aresetn", 1'b0, axil_aresetn);
            assert (mod_rst_done === 1'b0) else
                report_mismatch("mod_rst_done", 1'b0, mod_rst_done);
            assert (core_rstn === 1'b0) else
                report_mismatch("core_rstn", 1'b0, core_rstn);
        end
        // Core reset never released ahead of AXI-Lite
        if (axil_aresetn === 1'b0) begin
            assert (core_rstn === 1'b0) else
                report_mismatch("core_rstn", 1'b0, core_rstn);
        end
    end

    // ----------------------------------------------------------------------
    // Core domain comparison
    // ----------------------------------------------------------------------

    // Counts axis_aclk edges with axil_aresetn high
    // axil_aresetn never moves on an axis_aclk edge
    always @(posedge axis_aclk) begin
        if (axil_aresetn === 1'b1) begin
            core_edges = core_edges + 1;
        end else begin
            core_edges = 0;
        end
    end

    // Release on the SYNC_STAGES-th edge after axil_aresetn rises
    always @(negedge axis_aclk) begin
        if (!$isunknown(axil_aresetn)) begin
            exp_core = (axil_aresetn === 1'b1) &&
                       (core_edges >= reset_timing_pkg::SYNC_STAGES);
            assert (core_rstn === exp_core) else
                report_mismatch("core_rstn", exp_core, core_rstn);
        end
    end

    // Core clock is a straight wire
    always @(axis_aclk) begin
        #1;
        assert (core_clk === axis_aclk) else
            report_mismatch("core_clk", axis_aclk, core_clk);
    end

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------

    initial begin
        seed = 91728;
        since_release = -1;
        low_edges = 0;
        core_edges = 0;
        mod_rstn = 1'b0;
        axil_aclk = 1'b0;
        axis_aclk = 1'b0;

        // Power-on reset
        repeat (16) @(posedge axil_aclk);
        mod_rstn <= 1'b1;
        wait_axil_release();
        wait_core_release();

        for (int round = 0; round < 4; round++) begin
            // Sit in SEQ_DONE for a bit
            gap = rand_range(2, 10);
            repeat (gap) @(posedge axil_aclk);
            // Reassert after done
            pulse_reset(rand_range(1, 20));
            // Interrupt the wait phase
            // Count restarts from the new release
            gap = rand_range(reset_timing_pkg::SYNC_STAGES + 2,
                             expected_release_edges() - 10);
            repeat (gap) @(posedge axil_aclk);
            pulse_reset(rand_range(1, 20));
            wait_axil_release();
            wait_core_release();
        end

        repeat (4) @(posedge axil_aclk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule : tb_nic_reset_ctrl

// File: sources.f
common/reset_timing_pkg.sv
common/reset_types_pkg.sv
design/sync_reset.sv
design/reset_sequencer.sv
design/nic_reset_ctrl.sv
dv/tb_nic_reset_ctrl.sv

// File: Bender.yml
package:
  name: nic_reset_ctrl

sources:
  # Packages
  - files:
      - common/reset_timing_pkg.sv
      - common/reset_types_pkg.sv

  # RTL
  - files:
      - design/sync_reset.sv
      - design/reset_sequencer.sv
      - design/nic_reset_ctrl.sv

  # Testbench
  - target: test
    files:
      - dv/tb_nic_reset_ctrl.sv
